// ==== logic/mont_pkg.sv ====
`default_nettype none

package mont_pkg;

    // operand and digit sizes
    localparam int OPERAND_WIDTH = 1024;
    localparam int DIGIT_WIDTH   = 2;
    localparam int DIGIT_COUNT   = OPERAND_WIDTH / DIGIT_WIDTH;

    // room for C + 3B + 3M plus a sign bit for the final subtraction
    localparam int ACC_WIDTH     = OPERAND_WIDTH + 3;

    typedef logic [OPERAND_WIDTH-1:0]       operand_t;
    typedef logic [ACC_WIDTH-1:0]           acc_t;
    typedef logic [DIGIT_WIDTH-1:0]         digit_t;
    typedef logic [$clog2(DIGIT_COUNT)-1:0] count_t;

    // accumulator commands
    typedef enum logic [2:0] {
        ACC_HOLD,
        ACC_CLEAR,
        ACC_ADD,
        ACC_ADD_SHIFT,
        ACC_REDUCE
    } acc_op_t;

    // control FSM states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        ADD_B,
        ADD_M,
        REDUCE,
        FINISH
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/mont_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mont_ctrl (
    input  wire logic             clk,
    input  wire logic             resetn,
    input  wire logic             start,
    input  wire mont_pkg::digit_t a_digit,
    input  wire mont_pkg::digit_t acc_low,
    input  wire mont_pkg::digit_t m_low,
    output logic                  load,
    output logic                  use_m,
    output mont_pkg::digit_t      digit,
    output mont_pkg::acc_op_t     acc_op,
    output logic                  shift_a,
    output logic                  done
);

    mont_pkg::ctrl_state_t state;
    mont_pkg::ctrl_state_t state_next;
    mont_pkg::count_t      digit_cnt;
    mont_pkg::digit_t      qm_prod;
    mont_pkg::digit_t      q;
    logic                  start_seen;
    logic                  last_digit;

    // m is odd so it is its own inverse mod 4
    assign qm_prod    = acc_low * m_low;
    assign q          = 2'd0 - qm_prod;
    assign last_digit = (digit_cnt == mont_pkg::count_t'(mont_pkg::DIGIT_COUNT - 1));

    // start is registered once in IDLE, then acted on
    always_ff @(posedge clk) begin
        if (!resetn) begin
            start_seen <= 1'b0;
        end else begin
            start_seen <= (state == mont_pkg::IDLE) && start && !start_seen;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= mont_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // one count per finished digit
    always_ff @(posedge clk) begin
        if (!resetn) begin
            digit_cnt <= '0;
        end else if (state == mont_pkg::LOAD) begin
            digit_cnt <= '0;
        end else if (state == mont_pkg::ADD_M) begin
            digit_cnt <= digit_cnt + 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            mont_pkg::IDLE:   if (start_seen) state_next = mont_pkg::LOAD;
            mont_pkg::LOAD:   state_next = mont_pkg::ADD_B;
            mont_pkg::ADD_B:  state_next = mont_pkg::ADD_M;
            mont_pkg::ADD_M:  state_next = last_digit ? mont_pkg::REDUCE : mont_pkg::ADD_B;
            mont_pkg::REDUCE: state_next = mont_pkg::FINISH;
            mont_pkg::FINISH: state_next = mont_pkg::IDLE;
            default:          state_next = mont_pkg::IDLE;
        endcase
    end

    always_comb begin
        load    = 1'b0;
        use_m   = 1'b0;
        digit   = 2'd0;
        acc_op  = mont_pkg::ACC_HOLD;
        shift_a = 1'b0;
        done    = 1'b0;
        case (state)
            mont_pkg::LOAD: begin
                load   = 1'b1;
                acc_op = mont_pkg::ACC_CLEAR;
            end
            mont_pkg::ADD_B: begin
                digit  = a_digit;
                acc_op = mont_pkg::ACC_ADD;
            end
            mont_pkg::ADD_M: begin
                // clear the two low bits, then drop them
                use_m   = 1'b1;
                digit   = q;
                acc_op  = mont_pkg::ACC_ADD_SHIFT;
                shift_a = 1'b1;
            end
            mont_pkg::REDUCE: begin
                use_m  = 1'b1;
                digit  = 2'd1;
                acc_op = mont_pkg::ACC_REDUCE;
            end
            mont_pkg::FINISH: begin
                done = 1'b1;
            end
            default: begin
                acc_op = mont_pkg::ACC_HOLD;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/multiple_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module multiple_table (
    input  wire logic               clk,
    input  wire logic               resetn,
    input  wire logic               load,
    input  wire mont_pkg::operand_t b,
    input  wire mont_pkg::operand_t m,
    input  wire logic               use_m,
    input  wire mont_pkg::digit_t   digit,
    output mont_pkg::acc_t          multiple,
    output mont_pkg::digit_t        m_low
);

    // row 0 holds B, 2B, 3B and row 1 holds M, 2M, 3M
    mont_pkg::acc_t src [2];
    mont_pkg::acc_t dbl [2];
    mont_pkg::acc_t tbl [2][1:3];

    assign src[0] = mont_pkg::acc_t'(b);
    assign src[1] = mont_pkg::acc_t'(m);

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            dbl[s] = src[s] << 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < 2; s++) begin
                for (int k = 1; k <= 3; k++) begin
                    tbl[s][k] <= '0;
                end
            end
        end else if (load) begin
            for (int s = 0; s < 2; s++) begin
                tbl[s][1] <= src[s];
                tbl[s][2] <= dbl[s];
                // one adder per triple
                tbl[s][3] <= src[s] + dbl[s];
            end
        end
    end

    assign m_low = tbl[1][1][mont_pkg::DIGIT_WIDTH-1:0];

    // digit 0 selects nothing
    always_comb begin
        multiple = '0;
        if (digit != 2'd0) begin
            multiple = tbl[use_m][digit];
        end
    end

endmodule

`default_nettype wire

// ==== logic/digit_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module digit_shifter (
    input  wire logic               clk,
    input  wire logic               resetn,
    input  wire logic               load,
    input  wire logic               shift,
    input  wire mont_pkg::operand_t a,
    output mont_pkg::digit_t        a_digit
);

    mont_pkg::operand_t a_q;

    // load wins over shift
    always_ff @(posedge clk) begin
        if (!resetn) begin
            a_q <= '0;
        end else if (load) begin
            a_q <= a;
        end else if (shift) begin
            a_q <= a_q >> mont_pkg::DIGIT_WIDTH;
        end
    end

    // current radix-4 digit, least significant first
    assign a_digit = a_q[mont_pkg::DIGIT_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== logic/mont_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module mont_accumulator (
    input  wire logic              clk,
    input  wire logic              resetn,
    input  wire mont_pkg::acc_op_t acc_op,
    input  wire mont_pkg::acc_t    multiple,
    output mont_pkg::digit_t       acc_low,
    output mont_pkg::operand_t     result
);

    mont_pkg::acc_t c_q;
    mont_pkg::acc_t c_next;
    mont_pkg::acc_t sum;
    mont_pkg::acc_t diff;
    logic           diff_neg;

    // C stays below 2M, so C + 3B + 3M never overflows
    assign sum  = c_q + multiple;
    assign diff = c_q - multiple;

    // top bit set means C < M
    assign diff_neg = diff[mont_pkg::ACC_WIDTH-1];

    always_comb begin
        c_next = c_q;
        case (acc_op)
            mont_pkg::ACC_CLEAR: begin
                c_next = '0;
            end
            mont_pkg::ACC_ADD: begin
                c_next = sum;
            end
            mont_pkg::ACC_ADD_SHIFT: begin
                // low digit of sum is zero here
                c_next = sum >> mont_pkg::DIGIT_WIDTH;
            end
            mont_pkg::ACC_REDUCE: begin
                // a single subtraction suffices since C < 2M
                c_next = diff_neg ? c_q : diff;
            end
            default: begin
                c_next = c_q;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            c_q <= '0;
        end else begin
            c_q <= c_next;
        end
    end

    assign acc_low = c_q[mont_pkg::DIGIT_WIDTH-1:0];
    assign result  = c_q[mont_pkg::OPERAND_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== logic/mont_mult_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mont_mult_top (
    input  wire logic               clk,
    input  wire logic               resetn,
    input  wire logic               start,
    input  wire mont_pkg::operand_t a,
    input  wire mont_pkg::operand_t b,
    input  wire mont_pkg::operand_t m,
    output mont_pkg::operand_t      result,
    output logic                    done
);

    // control to datapath
    logic              load;
    logic              use_m;
    logic              shift_a;
    mont_pkg::digit_t  digit;
    mont_pkg::acc_op_t acc_op;

    // datapath status back to control
    mont_pkg::digit_t  a_digit;
    mont_pkg::digit_t  acc_low;
    mont_pkg::digit_t  m_low;
    mont_pkg::acc_t    multiple;

    mont_ctrl u_ctrl (
        .clk     (clk),
        .resetn  (resetn),
        .start   (start),
        .a_digit (a_digit),
        .acc_low (acc_low),
        .m_low   (m_low),
        .load    (load),
        .use_m   (use_m),
        .digit   (digit),
        .acc_op  (acc_op),
        .shift_a (shift_a),
        .done    (done)
    );

    multiple_table u_table (
        .clk      (clk),
        .resetn   (resetn),
        .load     (load),
        .b        (b),
        .m        (m),
        .use_m    (use_m),
        .digit    (digit),
        .multiple (multiple),
        .m_low    (m_low)
    );

    // A, two bits per digit
    digit_shifter u_shifter (
        .clk     (clk),
        .resetn  (resetn),
        .load    (load),
        .shift   (shift_a),
        .a       (a),
        .a_digit (a_digit)
    );

    mont_accumulator u_acc (
        .clk      (clk),
        .resetn   (resetn),
        .acc_op   (acc_op),
        .multiple (multiple),
        .acc_low  (acc_low),
        .result   (result)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic resetn
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // low for five rising edges, released just after the fifth
    initial begin
        resetn = 1'b0;
        repeat (5) @(posedge clk);
        #1 resetn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_mont_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mont_mult;

    logic               clk;
    logic               resetn;
    logic               start;
    mont_pkg::operand_t a;
    mont_pkg::operand_t b;
    mont_pkg::operand_t m;
    mont_pkg::operand_t result;
    logic               done;

    mont_pkg::operand_t expected;
    logic [31:0]        lcg_state;
    int                 done_count;
    int                 wait_limit = 2000;
    // start register, load, two cycles per digit, reduce
    int                 latency = 2 * mont_pkg::DIGIT_COUNT + 3;

    tb_clock_gen u_clock_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    mont_mult_top UUT (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .a      (a),
        .b      (b),
        .m      (m),
        .result (result),
        .done   (done)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // bit-serial Montgomery product, one bit of a per step
    function automatic mont_pkg::operand_t mont_ref(input mont_pkg::operand_t x,
                                                    input mont_pkg::operand_t y,
                                                    input mont_pkg::operand_t n);
        logic [mont_pkg::OPERAND_WIDTH+1:0] c;
        c = '0;
        for (int i = 0; i < mont_pkg::OPERAND_WIDTH; i++) begin
            if (x[i]) c = c + {2'b00, y};
            if (c[0]) c = c + {2'b00, n};
            c = c >> 1;
        end
        if (c >= {2'b00, n}) c = c - {2'b00, n};
        return c[mont_pkg::OPERAND_WIDTH-1:0];
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic random_operand(output mont_pkg::operand_t v);
        for (int w = 0; w < mont_pkg::OPERAND_WIDTH / 32; w++) begin
            lcg_state = lcg_next(lcg_state);
            v[w*32 +: 32] = lcg_state;
        end
    endtask

    // odd m with the top bit set, a and b with the top bit clear
    task automatic random_triple(output mont_pkg::operand_t x,
                                 output mont_pkg::operand_t y,
                                 output mont_pkg::operand_t n);
        random_operand(x);
        random_operand(y);
        random_operand(n);
        x[mont_pkg::OPERAND_WIDTH-1] = 1'b0;
        y[mont_pkg::OPERAND_WIDTH-1] = 1'b0;
        n[mont_pkg::OPERAND_WIDTH-1] = 1'b1;
        n[0] = 1'b1;
    endtask

    task automatic wait_for_reset;
        int cycles;
        cycles = 0;
        while (resetn !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles >= wait_limit) fail_now("reset was never released");
        end
    endtask

    task automatic check_done_low(input int n, input string msg);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            assert (done == 1'b0) else fail_now(msg);
        end
    endtask

    // one multiplication; busy_pulse_at > 0 pulses start again at that cycle
    task automatic run_mult(input mont_pkg::operand_t x, input mont_pkg::operand_t y,
                            input mont_pkg::operand_t n, input int busy_pulse_at);
        int   cycles;
        int   count_before;
        logic done_seen;
        expected = mont_ref(x, y, n);
        count_before = done_count;
        @(posedge clk);
        #1;
        a = x;
        b = y;
        m = n;
        start = 1'b1;
        // this edge samples start
        @(posedge clk);
        #1 start = 1'b0;
        cycles = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(posedge clk);
            cycles++;
            #1 start = (busy_pulse_at > 0) && (cycles == busy_pulse_at);
            @(negedge clk);
            done_seen = done;
            if (!done_seen && cycles >= wait_limit) begin
                fail_now("timeout: done never came after start");
            end
        end
        assert (cycles == latency) else begin
            $display("mismatch at %0t: latency got %0d expected %0d", $time, cycles, latency);
            fail_now("done came at the wrong cycle");
        end
        check_done_low(1, "done stayed high for more than one cycle");
        assert (done_count == count_before + 1) else begin
            fail_now("the compare process did not see exactly one done");
        end
    endtask

    // compare on every done
    always @(negedge clk) begin
        if (resetn && done) begin
            done_count = done_count + 1;
            assert (result == expected) else begin
                $display("mismatch at %0t: result got %h expected %h", $time, result, expected);
                fail_now("result differs from the reference model");
            end
        end
    end

    initial begin
        mont_pkg::operand_t a_val;
        mont_pkg::operand_t b_val;
        mont_pkg::operand_t m_val;
        start = 1'b0;
        a = '0;
        b = '0;
        m = '0;
        expected = '0;
        done_count = 0;
        lcg_state = 32'he47a2e10;

        wait_for_reset();
        check_done_low(10, "done went high before any start");

        for (int n = 0; n < 20; n++) begin
            random_triple(a_val, b_val, m_val);
            run_mult(a_val, b_val, m_val, 0);
        end

        // edge operands
        random_triple(a_val, b_val, m_val);
        run_mult('0, b_val, m_val, 0);
        assert (result == '0) else begin
            $display("mismatch at %0t: result got %h expected 0", $time, result);
            fail_now("a = 0 did not give 0");
        end
        run_mult(m_val - 1'b1, m_val - 1'b1, m_val, 0);
        run_mult(mont_pkg::operand_t'(1), mont_pkg::operand_t'(1), m_val, 0);

        // second start while busy must be dropped
        random_triple(a_val, b_val, m_val);
        run_mult(a_val, b_val, m_val, 100);
        check_done_low(1100, "a start while busy produced a second done");

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/mont_pkg.sv
logic/mont_ctrl.sv
logic/multiple_table.sv
logic/digit_shifter.sv
logic/mont_accumulator.sv
logic/mont_mult_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mont_mult.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mont_mult -f flist.f

output=$(./obj_dir/Vtb_mont_mult 2>&1) || true
echo "$output"

echo "$output" | grep -q "^TEST RESULT: PASS$"
